// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t; // Byte address.
    typedef logic [31:0] data_t; // One data word.
    typedef logic [3:0]  mask_t; // One bit per byte lane.
    typedef logic [3:0]  lat_t;  // Latency count, up to 15 cycles.

    // A single memory command. The fetch side always sends reads.
    typedef struct packed {
        logic  write; // Set for a write, clear for a read.
        addr_t addr;
        data_t wdata;
        mask_t wmask; // Lane i covers data bits 8i+7 down to 8i.
    } mem_req_t;

    typedef enum logic {
        ARB_IDLE = 1'b0, // No access in flight in the SRAM.
        ARB_BUSY = 1'b1  // Waiting for the SRAM done pulse.
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hw/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
    parameter int unsigned ADDR_BITS = 7,
    parameter int unsigned MAX_LAT   = 10,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  mem_pkg::mem_req_t req,
    output logic              done,
    output mem_pkg::data_t    rdata
);

    localparam int unsigned DEPTH = 2 ** ADDR_BITS;
    localparam logic [15:0] LFSR_TAPS = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1.
    localparam logic [15:0] LAT_RANGE = 16'(MAX_LAT);

    mem_pkg::data_t    mem [DEPTH];
    mem_pkg::mem_req_t req_q;
    mem_pkg::lat_t     count;
    logic [15:0]       lfsr;
    logic [15:0]       lfsr_next;
    logic [15:0]       lat_wide;
    mem_pkg::lat_t     lat_load;
    logic [ADDR_BITS-1:0] word_idx;
    logic              fire;

    if (MAX_LAT < 1 || MAX_LAT > 15) begin : g_lat_check
        $fatal(1, "sram_model: MAX_LAT must lie between 1 and 15");
    end

    if (LFSR_SEED == 16'h0000) begin : g_seed_check
        $fatal(1, "sram_model: LFSR_SEED must be nonzero");
    end

    // Galois form, shifting right. The feedback bit is the one shifted out.
    always_comb begin
        lfsr_next = {1'b0, lfsr[15:1]};
        if (lfsr[0]) begin
            lfsr_next = lfsr_next ^ LFSR_TAPS;
        end
    end

    // Map the fresh LFSR value into the range 1 to MAX_LAT.
    always_comb begin
        lat_wide = (lfsr_next % LAT_RANGE) + 16'd1;
        lat_load = mem_pkg::lat_t'(lat_wide);
    end

    assign word_idx = req_q.addr[ADDR_BITS+1:2]; // Upper address bits alias.
    assign fire     = (count == mem_pkg::lat_t'(1)); // Last cycle before done.

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else if (start) begin
            lfsr <= lfsr_next; // One step per access.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= lat_load;
        end else if (count != '0) begin
            count <= count - mem_pkg::lat_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= req; // Held for the whole access.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= fire;
        end
    end

    // The array access lands on the same edge that raises done.
    always_ff @(posedge clk) begin
        if (fire && req_q.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req_q.wmask[lane]) begin
                    mem[word_idx][8*lane +: 8] <= req_q.wdata[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !req_q.write) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_req,
    input  mem_pkg::addr_t    fetch_addr,
    output logic              fetch_done,
    output mem_pkg::data_t    fetch_data,
    input  logic              data_req,
    input  mem_pkg::mem_req_t data_cmd,
    output logic              data_done,
    output mem_pkg::data_t    data_rdata,
    output logic              start,
    output mem_pkg::mem_req_t req,
    input  logic              done,
    input  mem_pkg::data_t    rdata
);

    mem_pkg::arb_state_t state;
    logic                fetch_pend;
    logic                data_pend;
    mem_pkg::addr_t      fetch_addr_q;
    mem_pkg::mem_req_t   data_cmd_q;
    mem_pkg::mem_req_t   fetch_cmd;
    logic                grant_data;
    logic                last_data;   // Set when the data port was served last.
    logic                owner_data;  // Owner of the access in flight.
    logic                owner_write;
    logic                busy_done;
    mem_pkg::data_t      fetch_hold;
    mem_pkg::data_t      data_hold;

    // The fetch port only reads.
    always_comb begin
        fetch_cmd       = '0;
        fetch_cmd.write = 1'b0;
        fetch_cmd.addr  = fetch_addr_q;
    end

    // Round robin between the two pending requests.
    assign grant_data = data_pend && (!fetch_pend || !last_data);

    assign start = (state == mem_pkg::ARB_IDLE) && (fetch_pend || data_pend);
    assign req   = grant_data ? data_cmd_q : fetch_cmd;

    assign busy_done  = (state == mem_pkg::ARB_BUSY) && done;
    assign fetch_done = busy_done && !owner_data;
    assign data_done  = busy_done && owner_data;

    // Read data goes straight through in the done cycle, then holds.
    assign fetch_data = fetch_done ? rdata : fetch_hold;
    assign data_rdata = (data_done && !owner_write) ? rdata : data_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pend <= 1'b0;
        end else if (fetch_req) begin
            fetch_pend <= 1'b1;
        end else if (fetch_done) begin
            fetch_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_pend <= 1'b0;
        end else if (data_req) begin
            data_pend <= 1'b1;
        end else if (data_done) begin
            data_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fetch_addr_q <= fetch_addr;
        end
        if (data_req) begin
            data_cmd_q <= data_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mem_pkg::ARB_IDLE;
            last_data   <= 1'b0;
            owner_data  <= 1'b0;
            owner_write <= 1'b0;
        end else begin
            unique case (state)
                mem_pkg::ARB_IDLE: begin
                    if (start) begin
                        state       <= mem_pkg::ARB_BUSY;
                        owner_data  <= grant_data;
                        owner_write <= req.write;
                        last_data   <= grant_data;
                    end
                end
                mem_pkg::ARB_BUSY: begin
                    if (done) begin
                        state <= mem_pkg::ARB_IDLE; // Next grant can go out right away.
                    end
                end
                default: begin
                    state <= mem_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            fetch_hold <= rdata;
        end
        if (data_done && !owner_write) begin
            data_hold <= rdata; // A write leaves the last read word in place.
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_top #(
    parameter int unsigned ADDR_BITS = 7,
    parameter int unsigned MAX_LAT   = 10,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_req,
    input  mem_pkg::addr_t    fetch_addr,
    output logic              fetch_done,
    output mem_pkg::data_t    fetch_data,
    input  logic              data_req,
    input  mem_pkg::mem_req_t data_cmd,
    output logic              data_done,
    output mem_pkg::data_t    data_rdata
);

    logic              sram_start;
    mem_pkg::mem_req_t sram_req;
    logic              sram_done;
    mem_pkg::data_t    sram_rdata;

    mem_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .data_req   (data_req),
        .data_cmd   (data_cmd),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .start      (sram_start),
        .req        (sram_req),
        .done       (sram_done),
        .rdata      (sram_rdata)
    );

    // A single shared SRAM serves both ports.
    sram_model #(
        .ADDR_BITS (ADDR_BITS),
        .MAX_LAT   (MAX_LAT),
        .LFSR_SEED (LFSR_SEED)
    ) u_sram (
        .clk   (clk),
        .rst   (rst),
        .start (sram_start),
        .req   (sram_req),
        .done  (sram_done),
        .rdata (sram_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_checker #(
    parameter int unsigned MAX_LAT = 10
) (
    input logic clk,
    input logic rst,
    input logic fetch_req,
    input logic data_req,
    input logic fetch_pend,
    input logic data_pend,
    input logic fetch_done,
    input logic data_done,
    input logic start,
    input logic done
);

    localparam int WAIT_LIMIT = 2 * (int'(MAX_LAT) + 3);

    logic in_flight; // An SRAM access runs between start and done.
    int   fetch_age; // Cycles the current fetch has been pending.
    int   data_age;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (start) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !fetch_pend) begin
            fetch_age <= 0;
        end else begin
            fetch_age <= fetch_age + 1;
        end
        if (rst || !data_pend) begin
            data_age <= 0;
        end else begin
            data_age <= data_age + 1;
        end
    end

    a_sram_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("SRAM done stayed high for more than one cycle");
    a_fetch_done_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_done |=> !fetch_done)
        else $error("fetch_done stayed high for more than one cycle");
    a_data_done_pulse: assert property (@(posedge clk) disable iff (rst)
        data_done |=> !data_done)
        else $error("data_done stayed high for more than one cycle");
    a_fetch_done_owned: assert property (@(posedge clk) disable iff (rst)
        fetch_done |-> fetch_pend)
        else $error("fetch_done came while no fetch was pending");
    a_data_done_owned: assert property (@(posedge clk) disable iff (rst)
        data_done |-> data_pend)
        else $error("data_done came while no data request was pending");
    a_single_access: assert property (@(posedge clk) disable iff (rst) start |-> !in_flight)
        else $error("start was sent while an SRAM access was still in flight");
    a_fetch_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        fetch_req |-> !fetch_pend)
        else $error("fetch strobe arrived while a fetch was still pending");
    a_data_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        data_req |-> !data_pend)
        else $error("data strobe arrived while a data request was still pending");
    a_fetch_wait_bound: assert property (@(posedge clk) disable iff (rst)
        fetch_pend |-> fetch_age < WAIT_LIMIT)
        else $error("a fetch request waited longer than the latency bound");
    a_data_wait_bound: assert property (@(posedge clk) disable iff (rst)
        data_pend |-> data_age < WAIT_LIMIT)
        else $error("a data request waited longer than the latency bound");

endmodule

// Same latency bound as the DUT that mem_tb builds.
bind mem_arbiter mem_checker #(.MAX_LAT(10)) u_checker (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .data_req   (data_req),
    .fetch_pend (fetch_pend),
    .data_pend  (data_pend),
    .fetch_done (fetch_done),
    .data_done  (data_done),
    .start      (start),
    .done       (done)
);

`default_nettype wire

// ==== verif/mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_tb;

    localparam int unsigned ADDR_BITS  = 7;
    localparam int unsigned MAX_LAT    = 10;
    localparam int          DEPTH      = 2 ** ADDR_BITS;
    localparam int          WAIT_LIMIT = 2 * (int'(MAX_LAT) + 3);
    localparam int          RANDOM_OPS = 80;
    localparam int          TOTAL_OPS  = 60 + DEPTH + RANDOM_OPS; // All tests, rounded up.

    typedef logic [ADDR_BITS-1:0] idx_t;

    logic              clk;
    logic              rst;
    logic              fetch_req;
    mem_pkg::addr_t    fetch_addr;
    logic              fetch_done;
    mem_pkg::data_t    fetch_data;
    logic              data_req;
    mem_pkg::mem_req_t data_cmd;
    logic              data_done;
    mem_pkg::data_t    data_rdata;

    mem_pkg::data_t    ref_mem [DEPTH];
    mem_pkg::addr_t    fetch_q [$];
    mem_pkg::mem_req_t data_q [$];
    mem_pkg::data_t    last_rdata;    // Word the data port should still show.
    logic              rdata_known;
    logic              last_was_data; // Owner of the latest completion.
    logic              served_any;
    int                seed;
    mem_pkg::addr_t    base_addrs [6] = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0040,
                                          32'h0000_0100, 32'h0000_01fc, 32'h0000_0088};

    mem_top #(
        .ADDR_BITS (ADDR_BITS),
        .MAX_LAT   (MAX_LAT),
        .LFSR_SEED (16'h3c5b)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .data_req   (data_req),
        .data_cmd   (data_cmd),
        .data_done  (data_done),
        .data_rdata (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TOTAL_OPS * WAIT_LIMIT + 200) @(posedge clk);
        fail_run("Timeout: the tests did not finish in the expected number of cycles");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input mem_pkg::data_t expected,
                                input mem_pkg::data_t actual);
        fail_run($sformatf("error: %s expected 0x%08h, got 0x%08h", name, expected, actual));
    endtask

    function automatic idx_t word_index(input mem_pkg::addr_t addr);
        return addr[ADDR_BITS+1:2];
    endfunction

    function automatic mem_pkg::data_t lane_merge(input mem_pkg::data_t old_word,
                                                  input mem_pkg::data_t new_word,
                                                  input mem_pkg::mask_t mask);
        mem_pkg::data_t lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_word & ~lanes) | (new_word & lanes);
    endfunction

    task automatic queue_data(input logic write, input mem_pkg::addr_t addr,
                              input mem_pkg::data_t wdata, input mem_pkg::mask_t wmask);
        mem_pkg::mem_req_t cmd;
        cmd.write = write;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.wmask = wmask;
        data_q.push_back(cmd);
    endtask

    // Both ports issue from their queues, each strobing again right after its own done.
    task automatic run_traffic();
        mem_pkg::addr_t    f_addr;
        mem_pkg::mem_req_t d_cmd;
        mem_pkg::data_t    expected;
        logic              f_busy;
        logic              d_busy;
        logic              tie;
        int                f_wait;
        int                d_wait;
        int                f_passed; // Data accesses served while this fetch waited.
        int                d_passed;
        f_busy = 1'b0;
        d_busy = 1'b0;
        tie    = 1'b0;
        f_wait = 0;
        d_wait = 0;
        f_passed = 0;
        d_passed = 0;
        while (f_busy || d_busy || fetch_q.size() > 0 || data_q.size() > 0) begin
            @(posedge clk);
            fetch_req <= 1'b0;
            data_req  <= 1'b0;
            if (f_busy) begin
                f_wait++;
                assert (f_wait <= WAIT_LIMIT + 1) else fail_run("a fetch never completed");
            end
            if (d_busy) begin
                d_wait++;
                assert (d_wait <= WAIT_LIMIT + 1) else fail_run("a data access never completed");
            end
            if (fetch_done) begin
                assert (f_busy) else fail_run("fetch_done came with no fetch outstanding");
                expected = ref_mem[word_index(f_addr)];
                assert (fetch_data === expected) else report_value("fetch_data", expected, fetch_data);
                if (rdata_known) begin
                    assert (data_rdata === last_rdata)
                        else report_value("data_rdata", last_rdata, data_rdata);
                end
                if (tie) begin
                    assert (last_was_data) else fail_run("fetch won a tie although served last");
                    tie = 1'b0;
                end
                if (d_busy) begin
                    d_passed++;
                end
                assert (d_passed <= 1) else fail_run("a data access waited behind two fetches");
                last_was_data = 1'b0;
                served_any    = 1'b1;
                f_busy        = 1'b0;
            end
            if (data_done) begin
                assert (d_busy) else fail_run("data_done came with no data access outstanding");
                if (d_cmd.write) begin
                    ref_mem[word_index(d_cmd.addr)] =
                        lane_merge(ref_mem[word_index(d_cmd.addr)], d_cmd.wdata, d_cmd.wmask);
                    if (rdata_known) begin
                        assert (data_rdata === last_rdata)
                            else report_value("data_rdata", last_rdata, data_rdata);
                    end
                end else begin
                    expected = ref_mem[word_index(d_cmd.addr)];
                    assert (data_rdata === expected)
                        else report_value("data_rdata", expected, data_rdata);
                    last_rdata  = expected;
                    rdata_known = 1'b1;
                end
                if (tie) begin
                    assert (!last_was_data) else fail_run("data won a tie although served last");
                    tie = 1'b0;
                end
                if (f_busy) begin
                    f_passed++;
                end
                assert (f_passed <= 1) else fail_run("a fetch waited behind two data accesses");
                last_was_data = 1'b1;
                served_any    = 1'b1;
                d_busy        = 1'b0;
            end
            if (!f_busy && !d_busy && fetch_q.size() > 0 && data_q.size() > 0 && served_any) begin
                tie = 1'b1; // Both strobe together into an idle arbiter.
            end
            if (!f_busy && fetch_q.size() > 0) begin
                f_addr = fetch_q.pop_front();
                fetch_req  <= 1'b1;
                fetch_addr <= f_addr;
                f_busy   = 1'b1;
                f_wait   = 0;
                f_passed = 0;
            end
            if (!d_busy && data_q.size() > 0) begin
                d_cmd = data_q.pop_front();
                data_req <= 1'b1;
                data_cmd <= d_cmd;
                d_busy   = 1'b1;
                d_wait   = 0;
                d_passed = 0;
            end
        end
    endtask

    task automatic test_write_read();
        foreach (base_addrs[i]) begin
            queue_data(1'b1, base_addrs[i], $random(seed), 4'hf);
        end
        foreach (base_addrs[i]) begin
            queue_data(1'b0, base_addrs[i], '0, 4'h0);
        end
        run_traffic();
    endtask

    task automatic test_byte_masks();
        mem_pkg::mask_t masks [8];
        masks = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0110, 4'b0000};
        queue_data(1'b1, 32'h0000_0020, 32'h1122_3344, 4'hf);
        queue_data(1'b0, 32'h0000_0020, '0, 4'h0);
        foreach (masks[i]) begin
            queue_data(1'b1, 32'h0000_0020, $random(seed), masks[i]);
            queue_data(1'b0, 32'h0000_0020, '0, 4'h0);
        end
        run_traffic();
    endtask

    task automatic test_fetch_reads();
        foreach (base_addrs[i]) begin
            fetch_q.push_back(base_addrs[i]);
        end
        fetch_q.push_back(32'h0000_0020);
        run_traffic();
    endtask

    task automatic test_contention();
        for (int round = 0; round < 3; round++) begin
            fetch_q.push_back(base_addrs[round]);
            queue_data(1'b0, base_addrs[5 - round], '0, 4'h0);
            run_traffic();
        end
        for (int i = 0; i < 6; i++) begin
            fetch_q.push_back(base_addrs[i]);
            queue_data(i[0], base_addrs[5 - i], $random(seed), mem_pkg::mask_t'($random(seed)));
        end
        run_traffic();
    endtask

    task automatic test_random_traffic();
        mem_pkg::addr_t addr;
        int             op;
        for (int i = 0; i < DEPTH; i++) begin
            addr = mem_pkg::addr_t'(i * 4);
            queue_data(1'b1, addr, (addr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c, 4'hf);
        end
        run_traffic();
        queue_data(1'b1, 32'h8000_1234, 32'hcafe_f00d, 4'hf); // Lands on word 13.
        run_traffic();
        fetch_q.push_back(32'h0000_0034);
        queue_data(1'b0, 32'hffff_fe34, '0, 4'h0);
        run_traffic();
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op   = $random(seed) & 3;
            addr = $random(seed);
            if (op == 0) begin
                fetch_q.push_back(addr);
            end else begin
                queue_data(op >= 2, addr, $random(seed), mem_pkg::mask_t'($random(seed)));
            end
        end
        run_traffic();
    endtask

    initial begin
        seed          = 32'ha5d0_55aa;
        rst           = 1'b1;
        fetch_req     = 1'b0;
        fetch_addr    = '0;
        data_req      = 1'b0;
        data_cmd      = '0;
        last_rdata    = '0;
        rdata_known   = 1'b0;
        last_was_data = 1'b0;
        served_any    = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_write_read();
        test_byte_masks();
        test_fetch_reads();
        test_contention();
        test_random_traffic();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/mem_pkg.sv
hw/sram_model.sv
hw/mem_arbiter.sv
hw/mem_top.sv
verif/mem_checker.sv
verif/mem_tb.sv

// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vmem_tb: src.f hw/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 --top-module mem_tb -f src.f

test: obj_dir/Vmem_tb
	./obj_dir/Vmem_tb > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "Test failures found" $(SIM_LOG); then \
		echo "FAIL: see $(SIM_LOG)"; exit 1; \
	elif ! grep -q "All tests passed!" $(SIM_LOG); then \
		echo "FAIL: the run ended without a result, see $(SIM_LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)
